/* common/gb80_pkg.sv */
package gb80_pkg;

   // Bus widths
   typedef logic [15:0] addr_t;
   typedef logic [7:0]  data_t;

   // One bit per interrupt source, bit 0 has the highest priority
   typedef logic [4:0]  irq_t;

   // Memory map
   localparam addr_t hram_start = 16'hff80;
   localparam addr_t mmio_if    = 16'hff0f;
   localparam addr_t mmio_ie    = 16'hffff;

   // Interrupt sources
   //   0 vblank
   //   1 lcdc
   //   2 timer
   //   3 serial
   //   4 joypad
   localparam int irq_count = 5;

   // Source n jumps to irq_vector_base + 8 * n
   localparam data_t irq_vector_base = 8'h40;

endpackage

/* src/apb_mem_port.sv */
`timescale 1ns/1ns

module apb_mem_port
   import gb80_pkg::*;
#(
   parameter int hram_depth = 127
) (
   input  logic       clock,
   input  logic       reset,

   input  addr_t      paddr,
   input  logic       psel,
   input  logic       penable,
   input  logic       pwrite,
   input  data_t      pwdata,
   output data_t      prdata,
   output logic       pready,

   output addr_t      ext_addr,
   output data_t      ext_wdata,
   input  data_t      ext_rdata,
   output logic       mem_we,
   output logic       mem_re,
   input  logic       mem_disable,

   output logic       hram_we,
   output logic [6:0] hram_addr,
   output data_t      hram_wdata,
   input  data_t      hram_rdata,

   output logic       if_we,
   output logic       ie_we,
   output irq_t       reg_wdata,
   input  irq_t       if_flags,
   input  irq_t       ie_flags
);

   localparam addr_t hram_last = addr_t'(int'(hram_start) + hram_depth - 1);

   typedef enum logic [1:0] {
      st_idle,
      st_access,
      st_ext_data
   } state_t;

   state_t state;
   state_t state_next;

   logic   sel_hram;
   logic   sel_if;
   logic   sel_ie;
   logic   sel_ext;
   logic   access;
   logic   ext_access;
   data_t  data_buf;

   // Register addresses win over the high RAM window
   assign sel_ie   = (paddr == mmio_ie);
   assign sel_if   = (paddr == mmio_if);
   assign sel_hram = !sel_ie && (paddr >= hram_start) && (paddr <= hram_last);
   assign sel_ext  = !(sel_ie || sel_if || sel_hram);

   // First access cycle of a transfer
   assign access     = (state == st_access) && psel && penable;
   assign ext_access = access && sel_ext;

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (psel && !penable) begin
               state_next = st_access;
            end
         end
         st_access: begin
            if (!psel) begin
               state_next = st_idle;
            end else if (penable) begin
               state_next = sel_ext ? st_ext_data : st_idle;
            end
         end
         // Second cycle always ends the transfer
         default: state_next = st_idle;
      endcase
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         state <= st_idle;
      end else begin
         state <= state_next;
      end
   end

   // Data buffer holds the last byte that crossed the external port
   always_ff @(posedge clock) begin
      if (ext_access) begin
         if (mem_disable) begin
            data_buf <= '0;
         end else if (pwrite) begin
            data_buf <= pwdata;
         end else begin
            data_buf <= ext_rdata;
         end
      end
   end

   // Strobes last exactly the first access cycle
   assign mem_we    = ext_access && pwrite && !mem_disable;
   assign mem_re    = ext_access && !pwrite && !mem_disable;
   assign ext_addr  = paddr;
   assign ext_wdata = pwdata;

   assign hram_we    = access && sel_hram && pwrite;
   assign hram_addr  = 7'(paddr - hram_start);
   assign hram_wdata = pwdata;

   assign if_we     = access && sel_if && pwrite;
   assign ie_we     = access && sel_ie && pwrite;
   assign reg_wdata = pwdata[irq_count-1:0];

   // Local targets finish at once, external ones one cycle later
   assign pready = psel && penable &&
                   (((state == st_access) && !sel_ext) || (state == st_ext_data));

   always_comb begin
      if (state == st_ext_data) begin
         prdata = data_buf;
      end else if (sel_hram) begin
         prdata = hram_rdata;
      end else if (sel_if) begin
         prdata = data_t'(if_flags);
      end else if (sel_ie) begin
         prdata = data_t'(ie_flags);
      end else begin
         prdata = '0;
      end
   end

   strobe_exclusive: assert property (@(posedge clock) disable iff (reset)
      !(mem_we && mem_re));

   pready_in_access: assert property (@(posedge clock) disable iff (reset)
      pready |-> (psel && penable));

endmodule

/* src/hram.sv */
`timescale 1ns/1ns

module hram
   import gb80_pkg::*;
#(
   parameter int hram_depth = 127
) (
   input  logic       clock,
   input  logic       reset,
   input  logic       hram_we,
   input  logic [6:0] hram_addr,
   input  data_t      hram_wdata,
   output data_t      hram_rdata
);

   data_t                 mem [hram_depth];

   // One bit per byte, set once the byte has been written since reset
   logic [hram_depth-1:0] written;

   always_ff @(posedge clock) begin
      if (hram_we) begin
         mem[hram_addr] <= hram_wdata;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         written <= '0;
      end else if (hram_we) begin
         written[hram_addr] <= 1'b1;
      end
   end

   // Unwritten bytes read as zero
   assign hram_rdata = (int'(hram_addr) < hram_depth && written[hram_addr]) ?
                       mem[hram_addr] : '0;

   write_in_range: assert property (@(posedge clock) disable iff (reset)
      hram_we |-> (int'(hram_addr) < hram_depth));

endmodule

/* interrupt/irq_ctrl.sv */
`timescale 1ns/1ns

module irq_ctrl
   import gb80_pkg::*;
(
   input  logic  clock,
   input  logic  reset,
   input  irq_t  irq_raise,
   input  logic  irq_ack,
   input  logic  if_we,
   input  logic  ie_we,
   input  irq_t  reg_wdata,
   output irq_t  if_flags,
   output irq_t  ie_flags,
   output logic  irq_pending,
   output data_t irq_vector
);

   localparam int index_w = $clog2(irq_count);

   irq_t               active;
   logic [index_w-1:0] sel_index;
   irq_t               sel_mask;
   irq_t               clear_mask;

   assign active = if_flags & ie_flags;

   // Priority encoder, lowest set bit wins
   always_comb begin
      sel_index = '0;
      sel_mask  = '0;
      for (int i = irq_count - 1; i >= 0; i--) begin
         if (active[i]) begin
            sel_index = index_w'(i);
            sel_mask  = irq_t'(1) << i;
         end
      end
   end

   assign irq_pending = |active;

   // Vectors sit 8 bytes apart
   assign irq_vector = irq_vector_base + data_t'({sel_index, 3'b000});

   // Acknowledge drops only the flag being served
   assign clear_mask = irq_ack ? sel_mask : '0;

   // A raise in the same cycle is ORed in last, so it beats the clear
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         if_flags <= '0;
      end else if (if_we) begin
         if_flags <= reg_wdata | irq_raise;
      end else begin
         if_flags <= (if_flags & ~clear_mask) | irq_raise;
      end
   end

   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         ie_flags <= '0;
      end else if (ie_we) begin
         ie_flags <= reg_wdata;
      end
   end

   ack_while_pending: assert property (@(posedge clock) disable iff (reset)
      irq_ack |-> irq_pending);

endmodule

/* src/gb80_bus_unit.sv */
`timescale 1ns/1ns

module gb80_bus_unit
   import gb80_pkg::*;
#(
   parameter int hram_depth = 127
) (
   input  logic  clock,
   input  logic  reset,

   // APB slave
   input  addr_t paddr,
   input  logic  psel,
   input  logic  penable,
   input  logic  pwrite,
   input  data_t pwdata,
   output data_t prdata,
   output logic  pready,

   // External memory port
   output addr_t ext_addr,
   output data_t ext_wdata,
   input  data_t ext_rdata,
   output logic  mem_we,
   output logic  mem_re,
   input  logic  mem_disable,

   // Interrupts
   input  irq_t  irq_raise,
   input  logic  irq_ack,
   output logic  irq_pending,
   output data_t irq_vector,
   output irq_t  if_flags,
   output irq_t  ie_flags
);

   logic       hram_we;
   logic [6:0] hram_addr;
   data_t      hram_wdata;
   data_t      hram_rdata;

   logic       if_we;
   logic       ie_we;
   irq_t       reg_wdata;

   apb_mem_port #(
      .hram_depth (hram_depth)
   ) u_apb_mem_port (
      .clock       (clock),
      .reset       (reset),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .prdata      (prdata),
      .pready      (pready),
      .ext_addr    (ext_addr),
      .ext_wdata   (ext_wdata),
      .ext_rdata   (ext_rdata),
      .mem_we      (mem_we),
      .mem_re      (mem_re),
      .mem_disable (mem_disable),
      .hram_we     (hram_we),
      .hram_addr   (hram_addr),
      .hram_wdata  (hram_wdata),
      .hram_rdata  (hram_rdata),
      .if_we       (if_we),
      .ie_we       (ie_we),
      .reg_wdata   (reg_wdata),
      .if_flags    (if_flags),
      .ie_flags    (ie_flags)
   );

   hram #(
      .hram_depth (hram_depth)
   ) u_hram (
      .clock      (clock),
      .reset      (reset),
      .hram_we    (hram_we),
      .hram_addr  (hram_addr),
      .hram_wdata (hram_wdata),
      .hram_rdata (hram_rdata)
   );

   irq_ctrl u_irq_ctrl (
      .clock       (clock),
      .reset       (reset),
      .irq_raise   (irq_raise),
      .irq_ack     (irq_ack),
      .if_we       (if_we),
      .ie_we       (ie_we),
      .reg_wdata   (reg_wdata),
      .if_flags    (if_flags),
      .ie_flags    (ie_flags),
      .irq_pending (irq_pending),
      .irq_vector  (irq_vector)
   );

endmodule

/* testbench/tb_ext_mem.sv */
`timescale 1ns/1ns

module tb_ext_mem
   import gb80_pkg::*;
(
   input  logic  clock,
   input  logic  reset,
   input  addr_t ext_addr,
   input  data_t ext_wdata,
   input  logic  mem_we,
   input  logic  mem_re,
   output data_t ext_rdata,
   output addr_t last_waddr,
   output data_t last_wdata,
   output int    write_count
);

   // Nonzero while idle, so a read that leaks past the strobe shows up
   localparam data_t idle_data = 8'hee;

   // Read data depends only on the address
   always_comb begin
      if (mem_re) begin
         ext_rdata = ext_addr[15:8] ^ ext_addr[7:0];
      end else begin
         ext_rdata = idle_data;
      end
   end

   // Last write and number of write strobes seen
   always_ff @(posedge clock or posedge reset) begin
      if (reset) begin
         last_waddr  <= '0;
         last_wdata  <= '0;
         write_count <= 0;
      end else if (mem_we) begin
         last_waddr  <= ext_addr;
         last_wdata  <= ext_wdata;
         write_count <= write_count + 1;
      end
   end

endmodule

/* testbench/tb_gb80_bus.sv */
`timescale 1ns/1ns

module tb_gb80_bus
   import gb80_pkg::*;
();

   // Whole run takes well under 1000 cycles
   localparam int cycle_limit = 4000;

   logic  clock;
   logic  reset;
   addr_t paddr;
   logic  psel;
   logic  penable;
   logic  pwrite;
   data_t pwdata;
   data_t prdata;
   logic  pready;
   addr_t ext_addr;
   data_t ext_wdata;
   data_t ext_rdata;
   logic  mem_we;
   logic  mem_re;
   logic  mem_disable;
   irq_t  irq_raise;
   logic  irq_ack;
   logic  irq_pending;
   data_t irq_vector;
   irq_t  if_flags;
   irq_t  ie_flags;
   addr_t last_waddr;
   data_t last_wdata;
   int    write_count;

   string test_name = "reset";
   logic  chk_read = 1'b0;
   logic  probe = 1'b0;
   data_t exp_rdata = '0;
   int    acc_count = 0;
   addr_t exp_waddr = '0;
   data_t exp_wdata = '0;
   int    exp_writes = 0;
   irq_t  exp_if = '0;
   irq_t  exp_ie = '0;
   logic  ext_target;
   int    exp_wait;
   logic  exp_we;
   logic  exp_re;
   data_t exp_vec;

   gb80_bus_unit u_dut (.*);

   tb_ext_mem u_ext_mem (.*);

   initial begin
      clock = 1'b0;
      forever begin
         #10 clock = ~clock;
      end
   end

   // Memory map: anything outside the registers and 0xff80..0xfffe goes out
   assign ext_target = !((paddr == mmio_if) || (paddr == mmio_ie) ||
                         ((paddr >= hram_start) && (paddr <= 16'hfffe)));
   assign exp_wait   = ext_target ? 2 : 1;
   assign exp_we = psel && penable && (acc_count == 1) && ext_target && pwrite && !mem_disable;
   assign exp_re = psel && penable && (acc_count == 1) && ext_target && !pwrite && !mem_disable;
   assign exp_vec = data_t'(int'(irq_vector_base) + 8 * lowest_index(exp_if & exp_ie));

   // Access cycle number within the current transfer
   always @(posedge clock) begin
      if (psel && !penable) begin
         acc_count <= 1;
      end else if (psel && penable && !pready) begin
         acc_count <= acc_count + 1;
      end
   end

   function automatic int lowest_index(input irq_t active);
      int idx;
      idx = -1;
      for (int i = 0; i < irq_count; i++) begin
         if (active[i] && idx < 0) begin
            idx = i;
         end
      end
      return idx;
   endfunction

   task automatic stop_run();
      $display("Checks failed");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic fail_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
      $display("error %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
      stop_run();
   endtask

   // Setup cycle, then access cycles until pready
   task automatic transfer(input addr_t addr, input logic write, input data_t wdata,
                           input data_t exp);
      @(posedge clock);
      #2;
      paddr     = addr;
      pwrite    = write;
      pwdata    = wdata;
      psel      = 1'b1;
      penable   = 1'b0;
      chk_read  = !write;
      exp_rdata = exp;
      @(posedge clock);
      #2;
      penable = 1'b1;
      do begin
         @(posedge clock);
      end while (!pready);
      #2;
      psel     = 1'b0;
      penable  = 1'b0;
      chk_read = 1'b0;
   endtask

   task automatic probe_state();
      probe = 1'b1;
      @(posedge clock);
      #2;
      probe = 1'b0;
   endtask

   task automatic pulse_irq(input irq_t raise, input logic ack);
      irq_raise = raise;
      irq_ack   = ack;
      @(posedge clock);
      #2;
      irq_raise = '0;
      irq_ack   = 1'b0;
   endtask

   read_data: assert property (@(posedge clock) disable iff (reset)
      (chk_read && penable && pready) |-> (prdata == exp_rdata))
      else fail_value("read data", 32'(exp_rdata), 32'($sampled(prdata)));

   pready_timing: assert property (@(posedge clock) disable iff (reset)
      (psel && penable) |-> (pready == (acc_count == exp_wait)))
      else fail_value("pready", 32'($sampled(acc_count) == exp_wait), 32'($sampled(pready)));

   write_strobe: assert property (@(posedge clock) disable iff (reset) mem_we == exp_we)
      else fail_value("mem_we", 32'($sampled(exp_we)), 32'($sampled(mem_we)));

   read_strobe: assert property (@(posedge clock) disable iff (reset) mem_re == exp_re)
      else fail_value("mem_re", 32'($sampled(exp_re)), 32'($sampled(mem_re)));

   ext_address: assert property (@(posedge clock) disable iff (reset)
      (mem_we || mem_re) |-> ((ext_addr == paddr) && (ext_wdata == pwdata)))
      else fail_value("ext port", 32'({paddr, pwdata}),
                      32'({$sampled(ext_addr), $sampled(ext_wdata)}));

   ext_record: assert property (@(posedge clock) disable iff (reset)
      probe |-> ({8'(write_count), last_waddr, last_wdata} ==
                 {8'(exp_writes), exp_waddr, exp_wdata}))
      else fail_value("write record", {8'(exp_writes), exp_waddr, exp_wdata},
                      {8'(write_count), last_waddr, last_wdata});

   flag_state: assert property (@(posedge clock) disable iff (reset)
      probe |-> ({if_flags, ie_flags} == {exp_if, exp_ie}))
      else fail_value("flags", 32'({exp_if, exp_ie}),
                      32'({$sampled(if_flags), $sampled(ie_flags)}));

   pending_state: assert property (@(posedge clock) disable iff (reset)
      probe |-> (irq_pending == |(exp_if & exp_ie)))
      else fail_value("irq_pending", 32'(|(exp_if & exp_ie)), 32'($sampled(irq_pending)));

   vector_state: assert property (@(posedge clock) disable iff (reset)
      (probe && |(exp_if & exp_ie)) |-> (irq_vector == exp_vec))
      else fail_value("irq_vector", 32'(exp_vec), 32'($sampled(irq_vector)));

   initial begin : watchdog
      int cycles;
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge clock);
         cycles++;
      end
      $display("Timeout, the run did not finish within %0d cycles", cycle_limit);
      stop_run();
   end

   initial begin
      addr_t addrs [8];
      data_t datas [8];
      addr_t addr;
      data_t data;
      irq_t  bit_mask;
      void'($urandom(32'h48e9));
      reset       = 1'b1;
      paddr       = '0;
      psel        = 1'b0;
      penable     = 1'b0;
      pwrite      = 1'b0;
      pwdata      = '0;
      mem_disable = 1'b0;
      irq_raise   = '0;
      irq_ack     = 1'b0;
      repeat (4) @(posedge clock);
      #2;
      reset = 1'b0;

      // Distinct addresses, so the second pass also catches aliasing
      test_name = "hram";
      for (int i = 0; i < 8; i++) begin
         addrs[i] = addr_t'(32'hff80 + 16 * i + $urandom % 15);
         datas[i] = data_t'($urandom);
         transfer(addrs[i], 1'b1, datas[i], '0);
         transfer(addrs[i], 1'b0, '0, datas[i]);
      end
      for (int i = 0; i < 8; i++) begin
         transfer(addrs[i], 1'b0, '0, datas[i]);
      end

      test_name = "external";
      for (int i = 0; i < 8; i++) begin
         addr = addr_t'($urandom % 32'hff00);
         data = data_t'($urandom);
         transfer(addr, 1'b1, data, '0);
         exp_waddr = addr;
         exp_wdata = data;
         exp_writes++;
         probe_state();
         transfer(addr, 1'b0, '0, addr[15:8] ^ addr[7:0]);
      end

      test_name = "registers";
      for (int i = 0; i < 4; i++) begin
         data = data_t'($urandom);
         transfer(mmio_if, 1'b1, data, '0);
         transfer(mmio_if, 1'b0, '0, {3'b000, data[4:0]});
         exp_if = data[4:0];
         data = data_t'($urandom);
         transfer(mmio_ie, 1'b1, data, '0);
         transfer(mmio_ie, 1'b0, '0, {3'b000, data[4:0]});
         exp_ie = data[4:0];
         probe_state();
      end

      // Each pending case is followed by an acknowledge
      test_name = "priority";
      for (int i = 0; i < 24; i++) begin
         exp_if = irq_t'($urandom);
         exp_ie = irq_t'($urandom);
         transfer(mmio_if, 1'b1, data_t'(exp_if), '0);
         transfer(mmio_ie, 1'b1, data_t'(exp_ie), '0);
         probe_state();
         if ((exp_if & exp_ie) != '0) begin
            bit_mask = irq_t'(1) << lowest_index(exp_if & exp_ie);
            pulse_irq('0, 1'b1);
            exp_if = exp_if & ~bit_mask;
            probe_state();
         end
      end

      test_name = "raise";
      transfer(mmio_if, 1'b1, 8'h00, '0);
      transfer(mmio_ie, 1'b1, 8'h1f, '0);
      exp_if = '0;
      exp_ie = 5'h1f;
      for (int i = 0; i < 6; i++) begin
         bit_mask = irq_t'(1) << ($urandom % irq_count);
         pulse_irq(bit_mask, 1'b0);
         exp_if = exp_if | bit_mask;
         probe_state();
      end
      // Raise and acknowledge on the same source
      bit_mask = irq_t'(1) << lowest_index(exp_if);
      pulse_irq(bit_mask, 1'b1);
      probe_state();

      test_name = "mem_disable";
      mem_disable = 1'b1;
      for (int i = 0; i < 4; i++) begin
         addr = addr_t'($urandom % 32'hff00);
         transfer(addr, 1'b0, '0, 8'h00);
         transfer(addr, 1'b1, data_t'($urandom), '0);
      end
      probe_state();
      mem_disable = 1'b0;

      $display("All checks passed");
      $finish;
   end

endmodule

/* gb80_bus.f */
common/gb80_pkg.sv
src/apb_mem_port.sv
src/hram.sv
interrupt/irq_ctrl.sv
src/gb80_bus_unit.sv
testbench/tb_ext_mem.sv
testbench/tb_gb80_bus.sv

/* Makefile */
TOP := tb_gb80_bus

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f gb80_bus.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f gb80_bus.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log
